//--- verilog/aes_defines.svh
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// width of one block, also the AES-128 key width
`define AES_BLOCK_BITS 128

// bytes in a block, four columns of four rows
`define AES_BYTES 16

// rounds after the initial key addition
`define AES_ROUNDS 10

`endif

//--- verilog/aesPkg.sv
`default_nettype none

`include "aes_defines.svh"

package aesPkg;

	// byte 0 sits in the top bits, bytes run down each column
	typedef logic [`AES_BLOCK_BITS-1:0] aesBlockT;

	// round sequencing, fanned out from the controller
	typedef struct packed {
		logic load;       // start accepted this cycle
		logic advance;    // apply one round
		logic lastRound;  // round ten, no MixColumns
		logic [3:0] round; // 1..10, picks rcon
	} roundCtrlT;

	typedef enum logic [1:0] {
		stIdle,
		stRun,
		stFinish
	} ctrlStateT;

endpackage

`default_nettype wire

//--- verilog/sBoxLookup.sv
`timescale 1ns/1ns
`default_nettype none

module sBoxLookup (
	input wire logic [7:0] in,
	output logic [7:0] out
);

	// forward AES substitution, one row of the usual 16x16 table per pair of lines
	localparam logic [7:0] sBoxTable [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76, // 0x
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0, // 1x
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15, // 2x
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75, // 3x
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84, // 4x
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf, // 5x
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8, // 6x
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2, // 7x
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73, // 8x
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb, // 9x
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79, // ax
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08, // bx
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a, // cx
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e, // dx
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf, // ex
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16  // fx
	};

	assign out = sBoxTable[in]; // pure lookup, no clock

endmodule

`default_nettype wire

//--- verilog/aesControl.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_defines.svh"

module aesControl import aesPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic start,
	output roundCtrlT ctrl,
	output logic busy
);

	ctrlStateT state;
	logic [3:0] roundCnt; // round being applied while in run

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			roundCnt <= '0;
		end else begin
			case (state)
				stIdle: begin
					if (start) begin // starts while busy never reach here
						state <= stRun;
						roundCnt <= 4'd1;
					end
				end
				stRun: begin
					if (roundCnt == 4'(`AES_ROUNDS)) begin
						state <= stFinish;
						roundCnt <= '0;
					end else begin
						roundCnt <= roundCnt + 4'd1;
					end
				end
				stFinish: begin
					state <= stIdle; // output stage captures on this edge
				end
				default: begin
					state <= stIdle;
					roundCnt <= '0;
				end
			endcase
		end
	end

	always_comb begin
		ctrl.load = start && (state == stIdle);
		ctrl.advance = (state == stRun);
		ctrl.lastRound = (state == stRun) && (roundCnt == 4'(`AES_ROUNDS));
		ctrl.round = roundCnt;
	end

	assign busy = (state != stIdle); // falls on the edge that raises done

	// busy spans the whole block and drops on the done edge
	busyWindow: assert property (
		@(posedge clk) disable iff (!rstN)
		ctrl.load |-> ##(`AES_ROUNDS + 1) busy ##1 !busy
	);

	roundInRange: assert property (
		@(posedge clk) disable iff (!rstN)
		ctrl.round <= 4'(`AES_ROUNDS)
	);

endmodule

`default_nettype wire

//--- verilog/aesKeyExpand.sv
`timescale 1ns/1ns
`default_nettype none

module aesKeyExpand import aesPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire aesBlockT key,
	input wire roundCtrlT ctrl,
	output aesBlockT nextKey
);

	aesBlockT keyReg; // current round key
	logic [31:0] rotWord;
	logic [31:0] subWord;
	logic [31:0] tempWord;
	logic [7:0] rcon;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			keyReg <= '0;
		end else if (ctrl.load) begin
			keyReg <= key; // round 0 key is the cipher key
		end else if (ctrl.advance) begin
			keyReg <= nextKey;
		end
	end

	assign rotWord = {keyReg[23:0], keyReg[31:24]}; // RotWord of w3

	for (genvar i = 0; i < 4; i++) begin : gSubWord
		sBoxLookup uSBox (
			.in(rotWord[31-8*i -: 8]),
			.out(subWord[31-8*i -: 8])
		);
	end

	always_comb begin
		case (ctrl.round)
			4'd1: rcon = 8'h01;
			4'd2: rcon = 8'h02;
			4'd3: rcon = 8'h04;
			4'd4: rcon = 8'h08;
			4'd5: rcon = 8'h10;
			4'd6: rcon = 8'h20;
			4'd7: rcon = 8'h40;
			4'd8: rcon = 8'h80;
			4'd9: rcon = 8'h1b; // wraps through the AES polynomial
			4'd10: rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	end

	assign tempWord = subWord ^ {rcon, 24'h000000};

	// each new word chains off the one before it
	assign nextKey[127:96] = keyReg[127:96] ^ tempWord;
	assign nextKey[95:64] = keyReg[95:64] ^ nextKey[127:96];
	assign nextKey[63:32] = keyReg[63:32] ^ nextKey[95:64];
	assign nextKey[31:0] = keyReg[31:0] ^ nextKey[63:32];

endmodule

`default_nettype wire

//--- verilog/aesRound.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_defines.svh"

module aesRound import aesPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire aesBlockT plainText,
	input wire aesBlockT key,
	input wire roundCtrlT ctrl,
	input wire aesBlockT nextKey,
	output aesBlockT stateOut
);

	aesBlockT stateReg;
	aesBlockT subState;   // after SubBytes
	aesBlockT shiftState; // after ShiftRows
	aesBlockT mixState;   // after MixColumns
	aesBlockT roundResult;

	// multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [31:0] mixColumn(input logic [31:0] col);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {
			xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,  // 2 3 1 1
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,  // 1 2 3 1
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,  // 1 1 2 3
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)   // 3 1 1 2
		};
	endfunction

	for (genvar b = 0; b < `AES_BYTES; b++) begin : gSubBytes
		sBoxLookup uSBox (
			.in(stateReg[`AES_BLOCK_BITS-1-8*b -: 8]),
			.out(subState[`AES_BLOCK_BITS-1-8*b -: 8])
		);
	end

	// byte 4*c+r holds row r of column c, row r rotates left by r
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shiftState[127-8*(4*c+r) -: 8] = subState[127-8*(4*((c+r)%4)+r) -: 8];
			end
		end
	end

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			mixState[127-32*c -: 32] = mixColumn(shiftState[127-32*c -: 32]);
		end
	end

	assign roundResult = (ctrl.lastRound ? shiftState : mixState) ^ nextKey; // no mix in round ten

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stateReg <= '0;
		end else if (ctrl.load) begin
			stateReg <= plainText ^ key; // initial AddRoundKey
		end else if (ctrl.advance) begin
			stateReg <= roundResult;
		end
	end

	assign stateOut = stateReg;

endmodule

`default_nettype wire

//--- verilog/aesOutput.sv
`timescale 1ns/1ns
`default_nettype none

module aesOutput import aesPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire roundCtrlT ctrl,
	input wire aesBlockT stateOut,
	output aesBlockT cipherText,
	output logic done
);

	logic lastPassed; // round ten was applied on the previous edge

	always_ff @(posedge clk) begin
		if (!rstN) begin
			lastPassed <= 1'b0;
			done <= 1'b0;
			cipherText <= '0;
		end else begin
			lastPassed <= ctrl.advance && ctrl.lastRound;
			done <= lastPassed;
			if (lastPassed) begin
				cipherText <= stateOut; // held until the next block
			end
		end
	end

	// one pulse per block, back-to-back blocks are twelve cycles apart
	donePulse: assert property (
		@(posedge clk) disable iff (!rstN)
		done |=> !done
	);

endmodule

`default_nettype wire

//--- verilog/aesCore.sv
`timescale 1ns/1ns
`default_nettype none

module aesCore import aesPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic start,
	input wire aesBlockT plainText,
	input wire aesBlockT key,
	output logic busy,
	output logic done,
	output aesBlockT cipherText
);

	roundCtrlT ctrl;
	aesBlockT nextKey;
	aesBlockT stateOut;

	aesControl uControl (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.ctrl(ctrl),
		.busy(busy)
	);

	// key schedule runs in step with the rounds
	aesKeyExpand uKeyExpand (
		.clk(clk),
		.rstN(rstN),
		.key(key),
		.ctrl(ctrl),
		.nextKey(nextKey)
	);

	aesRound uRound (
		.clk(clk),
		.rstN(rstN),
		.plainText(plainText),
		.key(key),
		.ctrl(ctrl),
		.nextKey(nextKey),
		.stateOut(stateOut)
	);

	aesOutput uOutput (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.stateOut(stateOut),
		.cipherText(cipherText),
		.done(done)
	);

endmodule

`default_nettype wire

//--- bench/aesCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_defines.svh"

module aesCoreTb import aesPkg::*; ();

	logic clk;
	logic rstN;
	logic start;
	aesBlockT plainText;
	aesBlockT key;
	logic busy;
	logic done;
	aesBlockT cipherText;

	int cycleCnt = 0; // rising edges since time zero
	int errCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	integer seed;
	aesBlockT expQ [$]; // predictions for blocks in flight
	aesBlockT expected;

	aesCore u_aesCore (
		.clk(clk),
		.rstN(rstN),
		.start(start),
		.plainText(plainText),
		.key(key),
		.busy(busy),
		.done(done),
		.cipherText(cipherText)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk) cycleCnt <= cycleCnt + 1;

	// GF(2^8) multiply, shift and add
	function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ x;
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// inverse as a^254, zero maps to zero
	function automatic logic [7:0] gfInv(input logic [7:0] a);
		logic [7:0] sq;
		logic [7:0] r;
		sq = a;
		r = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gfMul(sq, sq);
			r = gfMul(r, sq);
		end
		return r;
	endfunction

	function automatic logic [7:0] refSub(input logic [7:0] b);
		logic [7:0] v;
		v = gfInv(b);
		return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]}
			^ {v[3:0], v[7:4]} ^ 8'h63; // affine transform
	endfunction

	function automatic aesBlockT aesRef(input aesBlockT pt, input aesBlockT k);
		logic [7:0] st [16];
		logic [7:0] rk [16];
		logic [7:0] tmp [16];
		logic [7:0] t [4];
		logic [7:0] rc;
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		aesBlockT res;
		rc = 8'h01;
		for (int i = 0; i < 16; i++) begin
			rk[i] = k[127-8*i -: 8];
			st[i] = pt[127-8*i -: 8] ^ rk[i];
		end
		for (int rnd = 1; rnd <= `AES_ROUNDS; rnd++) begin
			t[0] = refSub(rk[13]) ^ rc; // rotated last word
			t[1] = refSub(rk[14]);
			t[2] = refSub(rk[15]);
			t[3] = refSub(rk[12]);
			for (int i = 0; i < 16; i++) begin
				if (i < 4)
					rk[i] = rk[i] ^ t[i];
				else
					rk[i] = rk[i] ^ rk[i-4];
			end
			for (int c = 0; c < 4; c++)
				for (int r = 0; r < 4; r++)
					tmp[4*c+r] = refSub(st[4*((c+r)%4)+r]);
			for (int c = 0; c < 4; c++) begin
				a0 = tmp[4*c];
				a1 = tmp[4*c+1];
				a2 = tmp[4*c+2];
				a3 = tmp[4*c+3];
				if (rnd < `AES_ROUNDS) begin
					st[4*c] = gfMul(a0, 8'h02) ^ gfMul(a1, 8'h03) ^ a2 ^ a3;
					st[4*c+1] = a0 ^ gfMul(a1, 8'h02) ^ gfMul(a2, 8'h03) ^ a3;
					st[4*c+2] = a0 ^ a1 ^ gfMul(a2, 8'h02) ^ gfMul(a3, 8'h03);
					st[4*c+3] = gfMul(a0, 8'h03) ^ a1 ^ a2 ^ gfMul(a3, 8'h02);
				end else begin
					st[4*c] = a0;
					st[4*c+1] = a1;
					st[4*c+2] = a2;
					st[4*c+3] = a3;
				end
			end
			for (int i = 0; i < 16; i++)
				st[i] = st[i] ^ rk[i];
			rc = gfMul(rc, 8'h02);
		end
		for (int i = 0; i < 16; i++)
			res[127-8*i -: 8] = st[i];
		return res;
	endfunction

	function automatic aesBlockT randBlock();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// compares every result against the oldest prediction
	always @(negedge clk) begin
		if (rstN && done) begin
			if (expQ.size() == 0) begin
				$display("done pulsed at %0t ns with no block in flight", $time);
				errCount++;
			end else begin
				expected = expQ.pop_front();
				assert (cipherText == expected) else begin
					$display("Fail at %0t ns: cipherText is %h, expected %h",
						$time, cipherText, expected);
					errCount++;
				end
			end
		end
	end

	task automatic startBlock(input aesBlockT pt, input aesBlockT k, output int acceptCycle);
		@(posedge clk);
		start <= 1'b1;
		plainText <= pt;
		key <= k;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		acceptCycle = cycleCnt;
	endtask

	task automatic launchBlock(input aesBlockT pt, input aesBlockT k, output int acceptCycle);
		startBlock(pt, k, acceptCycle);
		if (busy) begin
			expQ.push_back(aesRef(pt, k));
		end else begin
			$display("start at %0t ns was not accepted", $time);
			errCount++;
		end
	endtask

	task automatic waitDone(input int acceptCycle);
		int waited;
		waited = 0;
		while (!done && waited < 40) begin
			assert (busy) else begin
				$display("Fail at %0t ns: busy is %b, expected 1", $time, busy);
				errCount++;
			end
			@(negedge clk);
			waited++;
		end
		if (!done) begin
			$display("timed out at %0t ns waiting for done", $time);
			errCount++;
		end else begin
			assert (cycleCnt - acceptCycle == `AES_ROUNDS + 1) else begin
				$display("Fail at %0t ns: done latency is %0d, expected %0d",
					$time, cycleCnt - acceptCycle, `AES_ROUNDS + 1);
				errCount++;
			end
			assert (!busy) else begin
				$display("Fail at %0t ns: busy is %b, expected 0", $time, busy);
				errCount++;
			end
			@(negedge clk);
			assert (!done) else begin
				$display("Fail at %0t ns: done is %b, expected 0", $time, done);
				errCount++;
			end
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		if (errCount == errBefore) begin
			$display("test %s: passed", name);
			testsPassed++;
		end else begin
			$display("test %s: failed with %0d errors", name, errCount - errBefore);
			testsFailed++;
		end
	endtask

	initial begin : mainSeq
		aesBlockT pt;
		aesBlockT k;
		aesBlockT refA;
		int c0;
		int c1;
		int errBefore;
		int waited;
		seed = 46;
		rstN = 1'b0;
		start = 1'b0;
		plainText = '0;
		key = '0;
		repeat (16) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);

		errBefore = errCount;
		assert (!busy && !done && cipherText == '0) else begin
			$display("Fail at %0t ns: busy/done/cipherText are %b/%b/%h, expected 0/0/0",
				$time, busy, done, cipherText);
			errCount++;
		end
		reportTest("after reset", errBefore);

		errBefore = errCount;
		pt = 128'h3243f6a8885a308d313198a2e0370734;
		k = 128'h2b7e151628aed2a6abf7158809cf4f3c;
		refA = aesRef(pt, k);
		assert (refA == 128'h3925841d02dc09fbdc118597196a0b32) else begin
			$display("Fail at %0t ns: aesRef is %h, expected %h", $time, refA,
				128'h3925841d02dc09fbdc118597196a0b32);
			errCount++;
		end
		launchBlock(pt, k, c0);
		waitDone(c0);
		reportTest("standard vector", errBefore);

		errBefore = errCount;
		launchBlock(randBlock(), randBlock(), c0);
		waitDone(c0); // latency, busy and pulse width
		reportTest("latency", errBefore);

		errBefore = errCount;
		for (int i = 0; i < 30; i++) begin
			if (i == 0) begin
				pt = '0;
				k = '0;
			end else if (i == 1) begin
				pt = '1;
				k = '1;
			end else begin
				pt = randBlock();
				k = randBlock();
			end
			launchBlock(pt, k, c0);
			waitDone(c0);
		end
		reportTest("random blocks", errBefore);

		errBefore = errCount;
		launchBlock(randBlock(), randBlock(), c0);
		repeat (4) @(negedge clk);
		startBlock(randBlock(), randBlock(), c1); // lands mid-block
		waitDone(c0);
		repeat (15) begin
			@(negedge clk);
			assert (!done) else begin
				$display("Fail at %0t ns: done is %b, expected 0", $time, done);
				errCount++;
			end
		end
		reportTest("start while busy", errBefore);

		errBefore = errCount;
		pt = randBlock();
		k = randBlock();
		refA = aesRef(pt, k);
		launchBlock(pt, k, c0);
		waitDone(c0);
		repeat (5) begin
			@(negedge clk);
			assert (cipherText == refA) else begin
				$display("Fail at %0t ns: cipherText is %h, expected %h",
					$time, cipherText, refA);
				errCount++;
			end
		end
		launchBlock(randBlock(), randBlock(), c0);
		waited = 0;
		while (cycleCnt != c0 + `AES_ROUNDS && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (cycleCnt != c0 + `AES_ROUNDS) begin
			$display("timed out at %0t ns waiting for the last round", $time);
			errCount++;
		end
		launchBlock(randBlock(), randBlock(), c1); // start high in the done cycle
		waitDone(c1);
		reportTest("held result and back-to-back", errBefore);

		if (expQ.size() != 0) begin
			$display("%0d blocks never produced a result", expQ.size());
			errCount++;
		end
		$display("%0d tests passed, %0d tests failed, %0d errors",
			testsPassed, testsFailed, errCount);
		if (errCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/aesPkg.sv
verilog/sBoxLookup.sv
verilog/aesControl.sv
verilog/aesKeyExpand.sv
verilog/aesRound.sv
verilog/aesOutput.sv
verilog/aesCore.sv
bench/aesCoreTb.sv
